// File: hdl/turf_io_pkg.sv
`default_nettype none

package turf_io_pkg;

    // One EMIO bank word, shared by input, output and tristate
    typedef logic [15:0] emio_word_t;

    ////////////////////////////////////////////////
    // EMIO bit layout
    ////////////////////////////////////////////////

    // Slow status inputs, bits 3 to 9 of the input word read zero
    localparam int EMIO_UART_IRQ_B     = 0;
    localparam int EMIO_HSK_IRQ        = 1;
    localparam int EMIO_HSK_COMPLETE   = 2;
    localparam int EMIO_PPS            = 10;
    localparam int EMIO_TIMEPULSE1     = 11;

    // GPS EXTINT drive lives in output bits 9:8
    localparam int EMIO_EXTINT_LSB     = 8;
    localparam int NUM_EXTINT          = 2;

    // TURFIO resets: readback on input, open-drain drive on output
    localparam int EMIO_RESET_LSB      = 12;

    ////////////////////////////////////////////////
    // Link counts
    ////////////////////////////////////////////////

    // One reset pin per TURFIO
    localparam int NUM_TURFIO          = 4;
    // Bridge valid map bits per link: none, aurora, two spare
    localparam int BRIDGE_GROUP_W      = 4;

endpackage

`default_nettype wire

// File: hdl/turf_id_pkg.sv
`default_nettype none

package turf_id_pkg;

    ////////////////////////////////////////////////
    // Identification
    ////////////////////////////////////////////////

    // "TURF" in ASCII, first character in the top byte
    localparam logic [31:0] ident_word = 32'h54555246;

    // Field view of the date/version word, listed from bit 31 down
    typedef struct packed {
        logic        rev_b;
        logic [14:0] date;
        logic [3:0]  ver_major;
        logic [3:0]  ver_minor;
        logic [7:0]  ver_rev;
    } dateversion_s;

    // Software sees the raw word, the register file fills the fields
    typedef union packed {
        logic [31:0]  raw;
        dateversion_s f;
    } dateversion_u;

    ////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////

    typedef logic [3:0] reg_addr_t;

    localparam reg_addr_t ADDR_IDENT       = 4'd0;
    localparam reg_addr_t ADDR_DATEVERSION = 4'd1;
    localparam reg_addr_t ADDR_EMIO_IN     = 4'd2;
    localparam reg_addr_t ADDR_EMIO_OUT    = 4'd3;
    localparam reg_addr_t ADDR_BRIDGE      = 4'd4;
    localparam reg_addr_t ADDR_BRIDGE_ERR  = 4'd5;

endpackage

`default_nettype wire

// File: hdl/emio_if.sv
`timescale 1ns/1ps
`default_nettype none

// EMIO words between the GPIO bank and the register file
interface emio_if;

    // Synchronized status and reset readback
    turf_io_pkg::emio_word_t gpio_in;
    // Software output word
    turf_io_pkg::emio_word_t gpio_out;
    // Software tristate word, 1 releases the pin
    turf_io_pkg::emio_word_t gpio_t;
    // Synchronizers have filled since reset
    logic                    in_valid;

    modport bank (
        output gpio_in,
        output in_valid,
        input  gpio_out,
        input  gpio_t
    );

    modport regs (
        input  gpio_in,
        input  in_valid,
        output gpio_out,
        output gpio_t
    );

endinterface

`default_nettype wire

// File: hdl/bridge_status_if.sv
`timescale 1ns/1ps
`default_nettype none

// Crate bridge status toward the register file
interface bridge_status_if #(
    parameter int NUM_LINKS = 4
);

    // Four valid bits per link
    logic [4*NUM_LINKS-1:0] valid_map;
    // Sticky error flags, one per link
    logic [NUM_LINKS-1:0]   timeout_flags;
    logic [NUM_LINKS-1:0]   invalid_flags;
    // Single-cycle clear from the register file
    logic                   err_clear;

    modport status (
        output valid_map,
        output timeout_flags,
        output invalid_flags,
        input  err_clear
    );

    modport regs (
        input  valid_map,
        input  timeout_flags,
        input  invalid_flags,
        output err_clear
    );

endinterface

`default_nettype wire

// File: hdl/emio_gpio_bank.sv
`timescale 1ns/1ps
`default_nettype none

module emio_gpio_bank #(
    parameter int SYNC_STAGES = 2
) (
    input  wire logic       ps_clk,
    input  wire logic       arst_n_i,
    emio_if.bank            emio,
    input  wire logic       uart_irq_b_i,
    input  wire logic       hsk_irq_i,
    input  wire logic       hsk_complete_i,
    input  wire logic       pps_pulse_i,
    input  wire logic       gps_timepulse1_i,
    input  wire logic [3:0] tresetb_i,
    output logic      [3:0] tresetb_o,
    output logic      [3:0] tresetb_oe_o,
    output logic      [1:0] gps_extint_o
);

    localparam int NRST   = turf_io_pkg::NUM_TURFIO;
    localparam int NEXT   = turf_io_pkg::NUM_EXTINT;
    localparam int RST_LO = turf_io_pkg::EMIO_RESET_LSB;
    localparam int EXT_LO = turf_io_pkg::EMIO_EXTINT_LSB;

    // Positions inside the synchronizer vector
    localparam int S_UART  = 0;
    localparam int S_HIRQ  = 1;
    localparam int S_HDONE = 2;
    localparam int S_PPS   = 3;
    localparam int S_TP1   = 4;
    localparam int S_RST   = 5;
    localparam int S_VALID = S_RST + NRST;
    localparam int SYNC_W  = S_VALID + 1;

    if (SYNC_STAGES < 2) begin : g_bad_stages
        $error("emio_gpio_bank needs at least two synchronizer stages");
    end

    logic [SYNC_W-1:0]                  async_in;
    logic [SYNC_STAGES-1:0][SYNC_W-1:0] sync_q;
    logic [SYNC_W-1:0]                  sync_out;
    turf_io_pkg::emio_word_t            in_word;

    //////////////////////////////////////////////////
    // Input synchronizers
    //////////////////////////////////////////////////

    // Constant 1 rides along so in_valid rises when the pipe is full
    assign async_in = {1'b1, tresetb_i, gps_timepulse1_i, pps_pulse_i,
                       hsk_complete_i, hsk_irq_i, uart_irq_b_i};

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], async_in};
        end
    end

    assign sync_out = sync_q[SYNC_STAGES-1];

    always_comb begin
        in_word = '0;
        in_word[turf_io_pkg::EMIO_UART_IRQ_B]   = sync_out[S_UART];
        in_word[turf_io_pkg::EMIO_HSK_IRQ]      = sync_out[S_HIRQ];
        in_word[turf_io_pkg::EMIO_HSK_COMPLETE] = sync_out[S_HDONE];
        in_word[turf_io_pkg::EMIO_PPS]          = sync_out[S_PPS];
        in_word[turf_io_pkg::EMIO_TIMEPULSE1]   = sync_out[S_TP1];
        in_word[RST_LO +: NRST]                 = sync_out[S_RST +: NRST];
    end

    assign emio.gpio_in  = in_word;
    assign emio.in_valid = sync_out[S_VALID];

    //////////////////////////////////////////////////
    // Pin drive
    //////////////////////////////////////////////////

    // Open-drain resets enable whenever software pulls the tristate low
    assign tresetb_o    = emio.gpio_out[RST_LO +: NRST];
    assign tresetb_oe_o = ~emio.gpio_t[RST_LO +: NRST];
    // EXTINT is a plain level held low while released
    assign gps_extint_o = emio.gpio_out[EXT_LO +: NEXT] & ~emio.gpio_t[EXT_LO +: NEXT];

    // Reset pin readback lands in the EMIO word after the synchronizer delay
    a_reset_readback: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
        emio.in_valid |-> (emio.gpio_in[RST_LO +: NRST] == $past(tresetb_i, SYNC_STAGES)));

endmodule

`default_nettype wire

// File: hdl/bridge_status.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_status #(
    parameter int NUM_LINKS   = 4,
    parameter int SYNC_STAGES = 2
) (
    input  wire logic                 ps_clk,
    input  wire logic                 arst_n_i,
    bridge_status_if.status           bst,
    input  wire logic [NUM_LINKS-1:0] aurora_up_i,
    input  wire logic [NUM_LINKS-1:0] bridge_timeout_i,
    input  wire logic [NUM_LINKS-1:0] bridge_invalid_i
);

    localparam int GW = turf_io_pkg::BRIDGE_GROUP_W;

    logic [SYNC_STAGES-1:0][NUM_LINKS-1:0] up_sync_q;
    logic [GW*NUM_LINKS-1:0]               valid_map;
    logic [NUM_LINKS-1:0]                  timeout_q;
    logic [NUM_LINKS-1:0]                  invalid_q;

    // Link-up comes from the Aurora user clock domain
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            up_sync_q <= '0;
        end else begin
            up_sync_q <= {up_sync_q[SYNC_STAGES-2:0], aurora_up_i};
        end
    end

    // Per link: bit 0 no-bridge, bit 1 aurora, upper two unimplemented
    always_comb begin
        valid_map = '0;
        for (int k = 0; k < NUM_LINKS; k++) begin
            valid_map[k*GW]     = 1'b1;
            valid_map[k*GW + 1] = up_sync_q[SYNC_STAGES-1][k];
        end
    end

    // Sticky errors, a pulse in the clear cycle survives the clear
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            timeout_q <= '0;
            invalid_q <= '0;
        end else begin
            timeout_q <= (timeout_q & ~{NUM_LINKS{bst.err_clear}}) | bridge_timeout_i;
            invalid_q <= (invalid_q & ~{NUM_LINKS{bst.err_clear}}) | bridge_invalid_i;
        end
    end

    assign bst.valid_map     = valid_map;
    assign bst.timeout_flags = timeout_q;
    assign bst.invalid_flags = invalid_q;

    // Software may always select the no-bridge target
    for (genvar k = 0; k < NUM_LINKS; k++) begin : g_none_chk
        a_none_valid: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
            bst.valid_map[k*GW]);
    end

endmodule

`default_nettype wire

// File: hdl/id_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module id_regfile #(
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd7,
    parameter logic [7:0]  VER_REV       = 8'd21,
    parameter logic [15:0] FIRMWARE_DATE = 16'h0000,
    parameter logic        REV_B         = 1'b0
) (
    input  wire logic                   ps_clk,
    input  wire logic                   arst_n_i,
    input  wire logic                   reg_wr_i,
    input  wire logic                   reg_rd_i,
    input  wire turf_id_pkg::reg_addr_t reg_addr_i,
    input  wire logic [31:0]            reg_wdata_i,
    output logic      [31:0]            reg_rdata_o,
    output logic                        reg_ack_o,
    emio_if.regs                        emio,
    bridge_status_if.regs               bst,
    output logic      [7:0]             bridge_type_o
);

    turf_id_pkg::dateversion_u dateversion;
    turf_io_pkg::emio_word_t   gpio_out_q;
    turf_io_pkg::emio_word_t   gpio_t_q;
    logic [7:0]                bridge_type_q;
    logic [31:0]               rdata_d;
    logic [31:0]               rdata_q;
    logic                      ack_q;

    // Version word, filled one field at a time
    always_comb begin
        dateversion.f.rev_b     = REV_B;
        dateversion.f.date      = FIRMWARE_DATE[14:0];
        dateversion.f.ver_major = VER_MAJOR;
        dateversion.f.ver_minor = VER_MINOR;
        dateversion.f.ver_rev   = VER_REV;
    end

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////

    always_comb begin
        rdata_d = '0;
        case (reg_addr_i)
            turf_id_pkg::ADDR_IDENT: begin
                rdata_d = turf_id_pkg::ident_word;
            end
            turf_id_pkg::ADDR_DATEVERSION: begin
                rdata_d = dateversion.raw;
            end
            turf_id_pkg::ADDR_EMIO_IN: begin
                // Hide the synchronizer fill after reset
                rdata_d[15:0] = emio.in_valid ? emio.gpio_in : 16'h0000;
            end
            turf_id_pkg::ADDR_EMIO_OUT: begin
                rdata_d = {gpio_t_q, gpio_out_q};
            end
            turf_id_pkg::ADDR_BRIDGE: begin
                rdata_d = {16'(bst.valid_map), 8'h00, bridge_type_q};
            end
            turf_id_pkg::ADDR_BRIDGE_ERR: begin
                rdata_d = {24'h000000, 4'(bst.invalid_flags), 4'(bst.timeout_flags)};
            end
            default: begin
                rdata_d = '0;
            end
        endcase
    end

    // Clear lands on the same edge that captures the flags, so nothing is lost
    assign bst.err_clear = reg_rd_i && (reg_addr_i == turf_id_pkg::ADDR_BRIDGE_ERR);

    //////////////////////////////////////////////////
    // Write side and strobe response
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_out_q    <= '0;
            gpio_t_q      <= '1;
            bridge_type_q <= '0;
            ack_q         <= 1'b0;
        end else begin
            ack_q <= reg_wr_i | reg_rd_i;
            if (reg_wr_i) begin
                case (reg_addr_i)
                    turf_id_pkg::ADDR_EMIO_OUT: begin
                        gpio_t_q   <= reg_wdata_i[31:16];
                        gpio_out_q <= reg_wdata_i[15:0];
                    end
                    turf_id_pkg::ADDR_BRIDGE: begin
                        bridge_type_q <= reg_wdata_i[7:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Read data holds between reads
    always_ff @(posedge ps_clk) begin
        if (reg_rd_i) begin
            rdata_q <= rdata_d;
        end
    end

    assign emio.gpio_out  = gpio_out_q;
    assign emio.gpio_t    = gpio_t_q;
    assign bridge_type_o  = bridge_type_q;
    assign reg_rdata_o    = rdata_q;
    assign reg_ack_o      = ack_q;

    a_one_strobe: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
        !(reg_rd_i && reg_wr_i));

    a_single_ack: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
        (reg_ack_o && !(reg_rd_i || reg_wr_i)) |=> !reg_ack_o);

endmodule

`default_nettype wire

// File: hdl/turf_ps_status.sv
`timescale 1ns/1ps
`default_nettype none

module turf_ps_status #(
    parameter int          NUM_LINKS     = 4,
    parameter int          SYNC_STAGES   = 2,
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd7,
    parameter logic [7:0]  VER_REV       = 8'd21,
    parameter logic [15:0] FIRMWARE_DATE = 16'h0000,
    parameter logic        REV_B         = 1'b0
) (
    input  wire logic                   ps_clk,
    input  wire logic                   arst_n_i,
    // Register port
    input  wire logic                   reg_wr_i,
    input  wire logic                   reg_rd_i,
    input  wire turf_id_pkg::reg_addr_t reg_addr_i,
    input  wire logic [31:0]            reg_wdata_i,
    output logic      [31:0]            reg_rdata_o,
    output logic                        reg_ack_o,
    // Slow status
    input  wire logic                   uart_irq_b_i,
    input  wire logic                   hsk_irq_i,
    input  wire logic                   hsk_complete_i,
    input  wire logic                   pps_pulse_i,
    input  wire logic                   gps_timepulse1_i,
    // TURFIO resets and GPS EXTINT
    input  wire logic [3:0]             tresetb_i,
    output logic      [3:0]             tresetb_o,
    output logic      [3:0]             tresetb_oe_o,
    output logic      [1:0]             gps_extint_o,
    // Crate bridge
    input  wire logic [NUM_LINKS-1:0]   aurora_up_i,
    input  wire logic [NUM_LINKS-1:0]   bridge_timeout_i,
    input  wire logic [NUM_LINKS-1:0]   bridge_invalid_i,
    output logic      [7:0]             bridge_type_o
);

    emio_if                                    u_emio_if ();
    bridge_status_if #(.NUM_LINKS(NUM_LINKS))  u_bst_if ();

    emio_gpio_bank #(.SYNC_STAGES(SYNC_STAGES))
        u_gpio_bank (.ps_clk(ps_clk), .arst_n_i(arst_n_i), .emio(u_emio_if.bank),
                     .uart_irq_b_i(uart_irq_b_i), .hsk_irq_i(hsk_irq_i),
                     .hsk_complete_i(hsk_complete_i), .pps_pulse_i(pps_pulse_i),
                     .gps_timepulse1_i(gps_timepulse1_i), .tresetb_i(tresetb_i),
                     .tresetb_o(tresetb_o), .tresetb_oe_o(tresetb_oe_o),
                     .gps_extint_o(gps_extint_o));

    bridge_status #(.NUM_LINKS(NUM_LINKS), .SYNC_STAGES(SYNC_STAGES))
        u_bridge_status (.ps_clk(ps_clk), .arst_n_i(arst_n_i), .bst(u_bst_if.status),
                         .aurora_up_i(aurora_up_i), .bridge_timeout_i(bridge_timeout_i),
                         .bridge_invalid_i(bridge_invalid_i));

    id_regfile #(.VER_MAJOR(VER_MAJOR), .VER_MINOR(VER_MINOR), .VER_REV(VER_REV),
                 .FIRMWARE_DATE(FIRMWARE_DATE), .REV_B(REV_B))
        u_id_regfile (.ps_clk(ps_clk), .arst_n_i(arst_n_i),
                      .reg_wr_i(reg_wr_i), .reg_rd_i(reg_rd_i),
                      .reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i),
                      .reg_rdata_o(reg_rdata_o), .reg_ack_o(reg_ack_o),
                      .emio(u_emio_if.regs), .bst(u_bst_if.regs),
                      .bridge_type_o(bridge_type_o));

endmodule

`default_nettype wire

// File: bench/tb_turf_ps_status.sv
`timescale 1ns/1ps
`default_nettype none

module tb_turf_ps_status;

    localparam int          CLK_PERIOD    = 20;
    localparam int          NUM_LINKS     = 4;
    localparam int          SYNC_STAGES   = 2;
    localparam logic [3:0]  VER_MAJOR     = 4'd1;
    localparam logic [3:0]  VER_MINOR     = 4'd3;
    localparam logic [7:0]  VER_REV       = 8'h2a;
    // Top date bit set, it must not reach the word
    localparam logic [15:0] FIRMWARE_DATE = 16'hc5e1;
    localparam logic        REV_B         = 1'b1;

    // Table operations
    localparam logic [1:0] OP_RD  = 2'd0;
    localparam logic [1:0] OP_WR  = 2'd1;
    localparam logic [1:0] OP_IN  = 2'd2;
    localparam logic [1:0] OP_ERR = 2'd3;

    // ins holds status in 4:0, reset pins in 8:5, link-up in 12:9
    // For error pulses ins holds timeouts in 3:0, invalids in 7:4
    typedef struct packed {
        logic [1:0]             op;
        turf_id_pkg::reg_addr_t addr;
        logic [31:0]            data;
        logic [31:0]            ins;
        logic [31:0]            exp;
    } entry_t;

    logic                   ps_clk = 1'b0;
    logic                   arst_n_i;
    logic                   reg_wr_i;
    logic                   reg_rd_i;
    turf_id_pkg::reg_addr_t reg_addr_i;
    logic [31:0]            reg_wdata_i;
    logic [31:0]            reg_rdata_o;
    logic                   reg_ack_o;
    logic                   uart_irq_b_i;
    logic                   hsk_irq_i;
    logic                   hsk_complete_i;
    logic                   pps_pulse_i;
    logic                   gps_timepulse1_i;
    logic [3:0]             tresetb_i;
    logic [3:0]             tresetb_o;
    logic [3:0]             tresetb_oe_o;
    logic [1:0]             gps_extint_o;
    logic [NUM_LINKS-1:0]   aurora_up_i;
    logic [NUM_LINKS-1:0]   bridge_timeout_i;
    logic [NUM_LINKS-1:0]   bridge_invalid_i;
    logic [7:0]             bridge_type_o;

    entry_t tbl[$];
    logic   table_ready = 1'b0;
    int     error_count = 0;

    turf_ps_status #(
        .NUM_LINKS(NUM_LINKS), .SYNC_STAGES(SYNC_STAGES),
        .VER_MAJOR(VER_MAJOR), .VER_MINOR(VER_MINOR), .VER_REV(VER_REV),
        .FIRMWARE_DATE(FIRMWARE_DATE), .REV_B(REV_B)
    ) dut (
        .ps_clk(ps_clk), .arst_n_i(arst_n_i),
        .reg_wr_i(reg_wr_i), .reg_rd_i(reg_rd_i), .reg_addr_i(reg_addr_i),
        .reg_wdata_i(reg_wdata_i), .reg_rdata_o(reg_rdata_o), .reg_ack_o(reg_ack_o),
        .uart_irq_b_i(uart_irq_b_i), .hsk_irq_i(hsk_irq_i),
        .hsk_complete_i(hsk_complete_i), .pps_pulse_i(pps_pulse_i),
        .gps_timepulse1_i(gps_timepulse1_i), .tresetb_i(tresetb_i),
        .tresetb_o(tresetb_o), .tresetb_oe_o(tresetb_oe_o), .gps_extint_o(gps_extint_o),
        .aurora_up_i(aurora_up_i), .bridge_timeout_i(bridge_timeout_i),
        .bridge_invalid_i(bridge_invalid_i), .bridge_type_o(bridge_type_o)
    );

    always #(CLK_PERIOD / 2) ps_clk = ~ps_clk;

    //////////////////////////////////////////////////
    // Expected values
    //////////////////////////////////////////////////

    function automatic logic [31:0] step_xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic turf_io_pkg::emio_word_t emio_in_expect(input logic [31:0] ins);
        turf_io_pkg::emio_word_t w;
        w        = '0;
        w[0]     = ins[0];
        w[1]     = ins[1];
        w[2]     = ins[2];
        w[10]    = ins[3];
        w[11]    = ins[4];
        w[15:12] = ins[8:5];
        return w;
    endfunction

    function automatic logic [15:0] valid_map_expect(input logic [3:0] up);
        logic [15:0] m;
        m = '0;
        for (int k = 0; k < 4; k++) begin
            m[4*k]     = 1'b1;
            m[4*k + 1] = up[k];
        end
        return m;
    endfunction

    // Order is bridge type, EXTINT, reset enables, reset levels
    function automatic logic [17:0] pins_expect(input logic [31:0] word,
                                                input logic [7:0] btype);
        return {btype, word[9:8] & ~word[25:24], ~word[31:28], word[15:12]};
    endfunction

    function automatic logic [17:0] pin_vector();
        return {bridge_type_o, gps_extint_o, tresetb_oe_o, tresetb_o};
    endfunction

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic abort_run();
        error_count++;
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input turf_id_pkg::dateversion_u got,
                              input turf_id_pkg::dateversion_u exp);
        if (got.raw !== exp.raw) begin
            $display("[FAIL] %s got %h expected %h", name, got.raw, exp.raw);
            abort_run();
        end
    endtask

    task automatic check_emio(input string name, input turf_io_pkg::emio_word_t got,
                              input turf_io_pkg::emio_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pins(input string name, input logic [17:0] got,
                              input logic [17:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ack(input logic exp, input string when);
        if (reg_ack_o !== exp) begin
            $display("[FAIL] reg_ack_o got %h expected %h (%s)", reg_ack_o, exp, when);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Table build and apply
    //////////////////////////////////////////////////

    function automatic void add_entry(input logic [1:0] op, input turf_id_pkg::reg_addr_t addr,
                                      input logic [31:0] data, input logic [31:0] ins,
                                      input logic [31:0] exp);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.data = data;
        e.ins  = ins;
        e.exp  = exp;
        tbl.push_back(e);
    endfunction

    task automatic build_table();
        logic [31:0]               rnd;
        logic [31:0]               ins;
        logic [31:0]               out_word;
        logic [7:0]                btype;
        logic [3:0]                to_acc;
        logic [3:0]                inv_acc;
        turf_id_pkg::dateversion_u dv;
        rnd      = 32'hf90c;
        ins      = '0;
        // Reset leaves every pin released and the outputs low
        out_word = 32'hffff0000;
        btype    = '0;
        dv.raw   = {REV_B, FIRMWARE_DATE[14:0], VER_MAJOR, VER_MINOR, VER_REV};
        add_entry(OP_RD, turf_id_pkg::ADDR_IDENT, '0, '0, 32'h54555246);
        add_entry(OP_RD, turf_id_pkg::ADDR_DATEVERSION, '0, '0, dv.raw);
        add_entry(OP_RD, turf_id_pkg::ADDR_EMIO_OUT, '0, '0, out_word);
        for (int i = 0; i < 6; i++) begin
            rnd = step_xorshift(rnd);
            ins = {19'd0, rnd[12:0]};
            add_entry(OP_IN, '0, '0, ins, '0);
            add_entry(OP_RD, turf_id_pkg::ADDR_EMIO_IN, '0, ins,
                      {16'h0000, emio_in_expect(ins)});
        end
        for (int i = 0; i < 6; i++) begin
            rnd      = step_xorshift(rnd);
            out_word = rnd;
            add_entry(OP_WR, turf_id_pkg::ADDR_EMIO_OUT, out_word, '0,
                      {14'd0, pins_expect(out_word, btype)});
            add_entry(OP_RD, turf_id_pkg::ADDR_EMIO_OUT, '0, '0, out_word);
        end
        for (int i = 0; i < 4; i++) begin
            rnd        = step_xorshift(rnd);
            ins[12:9]  = rnd[3:0];
            add_entry(OP_IN, '0, '0, ins, '0);
            add_entry(OP_RD, turf_id_pkg::ADDR_BRIDGE, '0, '0,
                      {valid_map_expect(ins[12:9]), 8'h00, btype});
            rnd   = step_xorshift(rnd);
            btype = rnd[7:0];
            add_entry(OP_WR, turf_id_pkg::ADDR_BRIDGE, rnd, '0,
                      {14'd0, pins_expect(out_word, btype)});
            add_entry(OP_RD, turf_id_pkg::ADDR_BRIDGE, '0, '0,
                      {valid_map_expect(ins[12:9]), 8'h00, btype});
        end
        for (int i = 0; i < 3; i++) begin
            to_acc  = '0;
            inv_acc = '0;
            // Two pulse bursts pile up in the sticky flags
            for (int j = 0; j < 2; j++) begin
                rnd     = step_xorshift(rnd);
                to_acc  = to_acc | rnd[3:0];
                inv_acc = inv_acc | rnd[7:4];
                add_entry(OP_ERR, '0, '0, {24'd0, rnd[7:0]}, '0);
            end
            add_entry(OP_RD, turf_id_pkg::ADDR_BRIDGE_ERR, '0, '0, {24'd0, inv_acc, to_acc});
            add_entry(OP_RD, turf_id_pkg::ADDR_BRIDGE_ERR, '0, '0, 32'd0);
        end
        add_entry(OP_RD, 4'hc, '0, '0, 32'd0);
    endtask

    // One strobe, ack must come exactly one cycle after it is sampled
    task automatic run_strobe(input logic wr, input turf_id_pkg::reg_addr_t addr,
                              input logic [31:0] data, output logic [31:0] rdata);
        @(negedge ps_clk);
        check_ack(1'b0, "idle before strobe");
        @(posedge ps_clk);
        reg_wr_i    <= wr;
        reg_rd_i    <= !wr;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(negedge ps_clk);
        check_ack(1'b0, "strobe not yet sampled");
        @(posedge ps_clk);
        reg_wr_i <= 1'b0;
        reg_rd_i <= 1'b0;
        @(negedge ps_clk);
        check_ack(1'b1, "one cycle after strobe");
        rdata = reg_rdata_o;
    endtask

    task automatic apply_entry(input entry_t e);
        logic [31:0] rdata;
        case (e.op)
            OP_IN: begin
                @(posedge ps_clk);
                uart_irq_b_i     <= e.ins[0];
                hsk_irq_i        <= e.ins[1];
                hsk_complete_i   <= e.ins[2];
                pps_pulse_i      <= e.ins[3];
                gps_timepulse1_i <= e.ins[4];
                tresetb_i        <= e.ins[8:5];
                aurora_up_i      <= e.ins[12:9];
                repeat (SYNC_STAGES + 2) @(posedge ps_clk);
            end
            OP_ERR: begin
                @(posedge ps_clk);
                bridge_timeout_i <= e.ins[3:0];
                bridge_invalid_i <= e.ins[7:4];
                @(posedge ps_clk);
                bridge_timeout_i <= '0;
                bridge_invalid_i <= '0;
                repeat (SYNC_STAGES + 2) @(posedge ps_clk);
            end
            OP_WR: begin
                run_strobe(1'b1, e.addr, e.data, rdata);
                check_pins("pins after write", pin_vector(), e.exp[17:0]);
            end
            default: begin
                run_strobe(1'b0, e.addr, '0, rdata);
                if (e.addr == turf_id_pkg::ADDR_EMIO_IN) begin
                    check_emio("reg_rdata_o[15:0] emio in", rdata[15:0], e.exp[15:0]);
                end
                check_word($sformatf("reg_rdata_o at address %h", e.addr), rdata, e.exp);
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Run
    //////////////////////////////////////////////////

    initial begin
        arst_n_i         = 1'b0;
        reg_wr_i         = 1'b0;
        reg_rd_i         = 1'b0;
        reg_addr_i       = '0;
        reg_wdata_i      = '0;
        uart_irq_b_i     = 1'b0;
        hsk_irq_i        = 1'b0;
        hsk_complete_i   = 1'b0;
        pps_pulse_i      = 1'b0;
        gps_timepulse1_i = 1'b0;
        tresetb_i        = '0;
        aurora_up_i      = '0;
        bridge_timeout_i = '0;
        bridge_invalid_i = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge ps_clk);
        arst_n_i <= 1'b1;
        @(negedge ps_clk);
        check_pins("pins after reset", pin_vector(), 18'h0);
        check_ack(1'b0, "after reset");
        for (int i = 0; i < tbl.size(); i++) begin
            apply_entry(tbl[i]);
        end
        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

    // Watchdog, no entry needs anywhere near 20 cycles
    initial begin
        longint limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = longint'(tbl.size()) * 20 * CLK_PERIOD;
        #(limit_ns);
        $display("Watchdog expired before the stimulus table finished");
        abort_run();
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/turf_io_pkg.sv
hdl/turf_id_pkg.sv
hdl/emio_if.sv
hdl/bridge_status_if.sv
hdl/emio_gpio_bank.sv
hdl/bridge_status.sv
hdl/id_regfile.sv
hdl/turf_ps_status.sv
bench/tb_turf_ps_status.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, then run and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f compile.f \
        --top-module tb_turf_ps_status -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
